// ==== addressing.f ====
+incdir+logic
logic/addressing_pkg.sv
logic/thread_number.sv
logic/default_offset_mem.sv
logic/indirect_offset_mem.sv
logic/address_translate.sv
logic/addressing.sv
logic/addressing_mapped.sv
bench/addressing_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the address translation testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module addressing_tb \
    -f addressing.f -o addressing_sim > build.log 2>&1 \
    && ./obj_dir/addressing_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

// ==== bench/addressing_tb.sv ====
// testbench for the address translation top level against a cycle-accurate reference model
`timescale 1ns/1ps
`default_nettype none

`include "addressing_macros.svh"

module addressing_tb;

    localparam int CLOCK_PERIOD = 100;
    // reset, six tests with their drain cycles, and the direct reset checks
    localparam int TEST_CYCLES  = 5 + 15 + 76 + 68 + 209 + 92 + 404;
    localparam int MARGIN       = 200;
    localparam logic [`ADDR_WIDTH-1:0] UNMAPPED [8] = '{
        10'h000, 10'h0FF, 10'h1FF, 10'h208, 10'h20F, 10'h250, 10'h2FF, 10'h3FF
    };

    // one read in flight through the two translation stages
    typedef struct packed {
        logic [`ADDR_WIDTH-1:0]         addr;
        logic [`THREAD_ADDR_WIDTH-1:0]  thread;
        logic                           held_shared;
        logic [`ADDR_WIDTH-1:0]         expected;
        logic                           bump;
        logic [`OFFSET_INDEX_WIDTH-1:0] bump_index;
        logic [`ADDR_WIDTH-1:0]         bump_value;
    } flight_t;

    logic                          clock = 1'b0;
    logic                          rst;
    logic [`ADDR_WIDTH-1:0]        addr_in;
    logic                          io_ready;
    logic [`D_OPERAND_WIDTH-1:0]   alu_write_addr;
    logic [`WORD_WIDTH-1:0]        alu_write_data;
    logic [`ADDR_WIDTH-1:0]        addr_out;

    logic [`ADDR_WIDTH-1:0]        offset_model [`THREAD_COUNT];
    logic [`ADDR_WIDTH-1:0]        ptr_model    [`OFFSET_ENTRIES];
    logic [`ADDR_WIDTH-1:0]        inc_model    [`OFFSET_ENTRIES];
    logic [`THREAD_ADDR_WIDTH-1:0] model_thread = '0;
    flight_t                       in_flight [$];
    logic                          check_valid = 1'b0;
    logic [`ADDR_WIDTH-1:0]        check_value = '0;
    int                            check_count = 0;
    int                            compare_errors = 0;
    int                            direct_errors = 0;
    int                            mark_checks = 0;
    int                            mark_errors = 0;

    addressing_mapped uut (
        .clock          (clock),
        .rst            (rst),
        .addr_in        (addr_in),
        .io_ready       (io_ready),
        .alu_write_addr (alu_write_addr),
        .alu_write_data (alu_write_data),
        .addr_out       (addr_out)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // ----------------------------------------
    // reference model

    function automatic logic in_window(
        input logic [`D_OPERAND_WIDTH-1:0] addr,
        input logic [`D_OPERAND_WIDTH-1:0] base,
        input int                          count
    );
        return (addr >= base) && (int'(addr - base) < count);
    endfunction

    // expected read address by class
    function automatic logic [`ADDR_WIDTH-1:0] reference_addr(
        input logic [`ADDR_WIDTH-1:0]        addr,
        input logic [`THREAD_ADDR_WIDTH-1:0] thread,
        input logic                          shared_only
    );
        if (shared_only || addr < `SHARED_LIMIT) begin
            return addr;
        end else if (addr >= `INDIRECT_BASE) begin
            return ptr_model[{thread, addr[1:0]}];
        end
        return addr + offset_model[thread];
    endfunction

    task automatic model_alu_write(
        input logic [`D_OPERAND_WIDTH-1:0] addr,
        input logic [`WORD_WIDTH-1:0]      data
    );
        logic [`D_OPERAND_WIDTH-1:0] rel;
        rel = addr - `DO_WRITE_BASE;
        if (in_window(addr, `DO_WRITE_BASE, `THREAD_COUNT)) begin
            offset_model[rel[2:0]] = data[`DO_WORD_OFFSET +: `ADDR_WIDTH];
        end
        rel = addr - `PO_WRITE_BASE;
        if (in_window(addr, `PO_WRITE_BASE, `OFFSET_ENTRIES)) begin
            ptr_model[rel[4:0]] = data[`PO_WORD_OFFSET +: `ADDR_WIDTH];
        end
        rel = addr - `INC_WRITE_BASE;
        if (in_window(addr, `INC_WRITE_BASE, `OFFSET_ENTRIES)) begin
            inc_model[rel[4:0]] = data[`INC_WORD_OFFSET +: `ADDR_WIDTH];
        end
    endtask

    // inputs seen here are the ones the DUT samples at the coming edge
    always @(negedge clock) begin : compare_step
        flight_t                     done_entry;
        flight_t                     stage_entry;
        flight_t                     new_entry;
        logic [`D_OPERAND_WIDTH-1:0] po_rel;
        logic                        po_hit;
        logic                        shared_only;
        if (check_valid) begin
            check_count = check_count + 1;
            if (addr_out !== check_value) begin
                compare_errors = compare_errors + 1;
                $display("Error: addr_out expected 0x%03h actual 0x%03h at %0t",
                         check_value, addr_out, $time);
            end
        end
        check_valid = 1'b0;
        // leaves stage 2 at the coming edge, its post-increment lands there too
        if (in_flight.size() == 2) begin
            done_entry  = in_flight.pop_front();
            check_valid = 1'b1;
            check_value = rst ? '0 : done_entry.expected;
            po_rel      = alu_write_addr - `PO_WRITE_BASE;
            po_hit      = in_window(alu_write_addr, `PO_WRITE_BASE, `OFFSET_ENTRIES)
                          && (po_rel[4:0] == done_entry.bump_index);
            if (done_entry.bump && !rst && !po_hit) begin
                ptr_model[done_entry.bump_index] = done_entry.bump_value;
            end
        end
        // enters stage 2, memories are read before this edge's writes
        if (in_flight.size() == 1) begin
            stage_entry            = in_flight[0];
            shared_only            = stage_entry.held_shared || rst;
            stage_entry.expected   = reference_addr(stage_entry.addr, stage_entry.thread,
                                                    shared_only);
            stage_entry.bump_index = {stage_entry.thread, stage_entry.addr[1:0]};
            stage_entry.bump       = !shared_only && (stage_entry.addr >= `INDIRECT_BASE)
                                     && io_ready;
            stage_entry.bump_value = ptr_model[stage_entry.bump_index]
                                     + inc_model[stage_entry.bump_index];
            in_flight[0]           = stage_entry;
        end
        model_alu_write(alu_write_addr, alu_write_data);
        new_entry             = '0;
        new_entry.addr        = addr_in;
        new_entry.thread      = model_thread;
        new_entry.held_shared = rst;
        in_flight.push_back(new_entry);
        model_thread = rst ? '0 : model_thread + 3'd1;
    end

    // ----------------------------------------
    // stimulus helpers

    function automatic logic [`WORD_WIDTH-1:0] random_word();
        return {4'($urandom_range(0, 15)), $urandom()};
    endfunction

    task automatic drive_cycle(
        input logic [`ADDR_WIDTH-1:0]      addr,
        input logic                        io,
        input logic [`D_OPERAND_WIDTH-1:0] waddr,
        input logic [`WORD_WIDTH-1:0]      wdata
    );
        @(posedge clock);
        addr_in        <= addr;
        io_ready       <= io;
        alu_write_addr <= waddr;
        alu_write_data <= wdata;
    endtask

    task automatic read_cycle(input logic [`ADDR_WIDTH-1:0] addr, input logic io);
        drive_cycle(addr, io, 10'h000, '0);
    endtask

    task automatic write_cycle(
        input logic [`D_OPERAND_WIDTH-1:0] waddr,
        input logic [`WORD_WIDTH-1:0]      wdata
    );
        drive_cycle(10'($urandom_range(0, 255)), 1'b0, waddr, wdata);
    endtask

    // drain the pipeline, then report this test
    task automatic finish_test(input string name);
        int errors_now;
        repeat (3) begin
            read_cycle(10'($urandom_range(0, 255)), 1'b0);
        end
        @(negedge clock);
        #1;
        errors_now = compare_errors + direct_errors;
        $display("%s: %0d checks, %0d errors", name, check_count - mark_checks,
                 errors_now - mark_errors);
        mark_checks = check_count;
        mark_errors = errors_now;
    endtask

    // ----------------------------------------
    initial begin : stimulus
        logic [`ADDR_WIDTH-1:0]        addr;
        logic [`ADDR_WIDTH-1:0]        ptr;
        logic [`ADDR_WIDTH-1:0]        inc;
        logic [`D_OPERAND_WIDTH-1:0]   waddr;
        logic [`WORD_WIDTH-1:0]        word;
        logic [`THREAD_ADDR_WIDTH-1:0] bump_thread;
        int                            total_errors;
        void'($urandom(32'h2a60d2d6));
        rst            = 1'b1;
        addr_in        = '0;
        io_ready       = 1'b0;
        alu_write_addr = '0;
        alu_write_data = '0;

        for (int i = 0; i < 5; i++) begin
            read_cycle(10'($urandom_range(0, 255)), 1'b0);
            if (i == 4) begin
                rst <= 1'b0;
            end
            @(negedge clock);
            if (addr_out !== '0) begin
                direct_errors = direct_errors + 1;
                $display("Error: addr_out expected 0x000 actual 0x%03h during reset", addr_out);
            end
        end
        repeat (12) read_cycle(10'($urandom_range(0, 255)), 1'b0);
        finish_test("reset state");

        for (int t = 0; t < `THREAD_COUNT; t++) begin
            write_cycle(`DO_WRITE_BASE + 10'(t), random_word());
        end
        repeat (64) read_cycle(10'($urandom_range(256, 1019)), 1'b0);
        finish_test("default offsets");

        for (int e = 0; e < `OFFSET_ENTRIES; e++) begin
            write_cycle(`PO_WRITE_BASE + 10'(e), random_word());
        end
        for (int i = 0; i < 32; i++) begin
            read_cycle(`INDIRECT_BASE + 10'((i / 8) % 4), 1'b0);
        end
        finish_test("programmed pointers");

        for (int e = 0; e < `OFFSET_ENTRIES; e++) begin
            write_cycle(`INC_WRITE_BASE + 10'(e), random_word());
        end
        // thread 0 slot 0 has to wrap past 1023
        write_cycle(`PO_WRITE_BASE, 36'h0000003F8);
        write_cycle(`INC_WRITE_BASE, 36'h000010000);
        for (int i = 0; i < 128; i++) begin
            read_cycle(`INDIRECT_BASE + 10'((i / 8) % 4), i < 64);
        end
        for (int i = 0; i < 32; i++) begin
            read_cycle(`INDIRECT_BASE + 10'((i / 8) % 4), 1'($urandom_range(0, 1)));
        end
        // ALU pointer write lands on the same edge as that entry's post-increment
        read_cycle(`INDIRECT_BASE + 10'd2, 1'b0);
        bump_thread = model_thread;
        read_cycle(10'($urandom_range(0, 255)), 1'b1);
        write_cycle(`PO_WRITE_BASE + 10'({bump_thread, 2'b10}), random_word());
        repeat (8) read_cycle(`INDIRECT_BASE + 10'd2, 1'b0);
        finish_test("post-increment");

        for (int u = 0; u < 8; u++) begin
            write_cycle(UNMAPPED[u], random_word());
        end
        for (int j = 0; j < 4; j++) begin
            ptr  = 10'($urandom_range(0, 1023));
            inc  = ~ptr;
            word = {14'($urandom_range(0, 16383)), inc, 2'b11, ptr};
            write_cycle(`PO_WRITE_BASE + 10'(7 * j + 3), word);
            write_cycle(`INC_WRITE_BASE + 10'(7 * j + 3), word);
        end
        for (int i = 0; i < 64; i++) begin
            read_cycle(`INDIRECT_BASE + 10'((i / 8) % 4), i < 32);
        end
        repeat (8) read_cycle(10'($urandom_range(256, 1019)), 1'b0);
        finish_test("write map and field slicing");

        for (int i = 0; i < 400; i++) begin
            case ($urandom_range(0, 2))
                0:       addr = 10'($urandom_range(0, 255));
                1:       addr = 10'($urandom_range(256, 1019));
                default: addr = `INDIRECT_BASE + 10'($urandom_range(0, 3));
            endcase
            if ($urandom_range(0, 3) == 0) begin
                waddr = 10'($urandom_range('h1F8, 'h257));
            end else begin
                waddr = 10'h000;
            end
            drive_cycle(addr, 1'($urandom_range(0, 1)), waddr, random_word());
        end
        finish_test("mixed random traffic");

        total_errors = compare_errors + direct_errors;
        $display("summary: %0d checks, %0d errors", check_count, total_errors);
        if (total_errors == 0 && check_count > 0) begin
            $display("Test OK");
        end else begin
            if (check_count == 0) begin
                $display("no output was ever compared");
            end
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #((TEST_CYCLES + MARGIN) * CLOCK_PERIOD);
        $display("watchdog: run went past its cycle budget");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/addressing_mapped.sv ====
// address translation top level holding the ALU write map and data field slicing
`timescale 1ns/1ps
`default_nettype none

`include "addressing_macros.svh"

module addressing_mapped (
    input  logic                            clock,
    input  logic                            rst,
    input  logic [`ADDR_WIDTH-1:0]          addr_in,
    input  logic                            io_ready,
    input  logic [`D_OPERAND_WIDTH-1:0]     alu_write_addr,
    input  logic [`WORD_WIDTH-1:0]          alu_write_data,
    output logic [`ADDR_WIDTH-1:0]          addr_out
);

    addressing_pkg::offset_write_t do_write;
    addressing_pkg::offset_write_t po_write;
    addressing_pkg::offset_write_t inc_write;

    // hit test and entry number for one write window
    function automatic addressing_pkg::offset_write_t decode_write(
        input logic [`D_OPERAND_WIDTH-1:0] addr,
        input logic [`D_OPERAND_WIDTH-1:0] base,
        input logic [`D_OPERAND_WIDTH-1:0] count,
        input logic [`ADDR_WIDTH-1:0]      data
    );
        logic [`D_OPERAND_WIDTH-1:0] rel;
        rel = addr - base;
        decode_write.en    = (addr >= base) && (rel < count);
        decode_write.index = rel[`OFFSET_INDEX_WIDTH-1:0];
        decode_write.data  = data;
    endfunction

    // ----------------------------------------
    // write map, all combinational
    always_comb begin
        do_write  = decode_write(alu_write_addr, `DO_WRITE_BASE, `DO_WRITE_COUNT,
                                 alu_write_data[`DO_WORD_OFFSET +: `ADDR_WIDTH]);
        po_write  = decode_write(alu_write_addr, `PO_WRITE_BASE, `PO_WRITE_COUNT,
                                 alu_write_data[`PO_WORD_OFFSET +: `ADDR_WIDTH]);
        // increment lives in its own field of the word
        inc_write = decode_write(alu_write_addr, `INC_WRITE_BASE, `INC_WRITE_COUNT,
                                 alu_write_data[`INC_WORD_OFFSET +: `ADDR_WIDTH]);
    end

    // ----------------------------------------
    addressing u_addressing (
        .clock      (clock),
        .rst        (rst),
        .addr_in    (addr_in),
        .io_ready   (io_ready),
        .do_write   (do_write),
        .po_write   (po_write),
        .inc_write  (inc_write),
        .addr_out   (addr_out)
    );

endmodule

`default_nettype wire

// ==== logic/addressing.sv ====
// translation core joining the thread counter, offset memories and translator
`timescale 1ns/1ps
`default_nettype none

`include "addressing_macros.svh"

module addressing (
    input  logic                            clock,
    input  logic                            rst,
    input  logic [`ADDR_WIDTH-1:0]          addr_in,
    input  logic                            io_ready,
    input  addressing_pkg::offset_write_t   do_write,
    input  addressing_pkg::offset_write_t   po_write,
    input  addressing_pkg::offset_write_t   inc_write,
    output logic [`ADDR_WIDTH-1:0]          addr_out
);

    logic [`THREAD_ADDR_WIDTH-1:0]  thread;
    logic [`THREAD_ADDR_WIDTH-1:0]  thread_d;
    logic [`SLOT_ADDR_WIDTH-1:0]    rd_slot;
    logic [`OFFSET_INDEX_WIDTH-1:0] rd_index;
    logic [`ADDR_WIDTH-1:0]         default_offset;
    logic [`ADDR_WIDTH-1:0]         pointer;
    logic                           bump;
    logic [`OFFSET_INDEX_WIDTH-1:0] bump_index;

    thread_number u_thread_number (
        .clock      (clock),
        .rst        (rst),
        .thread     (thread),
        .thread_d   (thread_d)
    );

    // ----------------------------------------
    // memory reads for the address held in stage 1
    assign rd_index = {thread_d, rd_slot};

    default_offset_mem u_default_offset_mem (
        .clock      (clock),
        .wr         (do_write),
        .rd_thread  (thread_d),
        .offset     (default_offset)
    );

    indirect_offset_mem u_indirect_offset_mem (
        .clock      (clock),
        .rst        (rst),
        .po_wr      (po_write),
        .inc_wr     (inc_write),
        .rd_index   (rd_index),
        .bump       (bump),
        .bump_index (bump_index),
        .pointer    (pointer)
    );

    // ----------------------------------------
    address_translate u_address_translate (
        .clock          (clock),
        .rst            (rst),
        .addr_in        (addr_in),
        .thread         (thread),
        .thread_d       (thread_d),
        .io_ready       (io_ready),
        .default_offset (default_offset),
        .pointer        (pointer),
        .rd_slot        (rd_slot),
        .bump           (bump),
        .bump_index     (bump_index),
        .addr_out       (addr_out)
    );

endmodule

`default_nettype wire

// ==== logic/address_translate.sv ====
// two-stage translator: classify the read address, then select the output address
`timescale 1ns/1ps
`default_nettype none

`include "addressing_macros.svh"

module address_translate (
    input  logic                            clock,
    input  logic                            rst,
    input  logic [`ADDR_WIDTH-1:0]          addr_in,
    input  logic [`THREAD_ADDR_WIDTH-1:0]   thread,
    input  logic [`THREAD_ADDR_WIDTH-1:0]   thread_d,
    input  logic                            io_ready,
    input  logic [`ADDR_WIDTH-1:0]          default_offset,
    input  logic [`ADDR_WIDTH-1:0]          pointer,
    output logic [`SLOT_ADDR_WIDTH-1:0]     rd_slot,
    output logic                            bump,
    output logic [`OFFSET_INDEX_WIDTH-1:0]  bump_index,
    output logic [`ADDR_WIDTH-1:0]          addr_out
);

    addressing_pkg::addr_class_e      cls;
    addressing_pkg::translate_stage_t stage_1;
    addressing_pkg::translate_stage_t stage_2;
    logic                             io_ready_q;

    // ----------------------------------------
    // stage 1: classify and capture

    always_comb begin
        if (addr_in < `SHARED_LIMIT) begin
            cls = addressing_pkg::class_shared;
        end else if (addr_in >= `INDIRECT_BASE) begin
            cls = addressing_pkg::class_indirect;
        end else begin
            cls = addressing_pkg::class_private;
        end
    end

    always_ff @(posedge clock) begin
        stage_1.addr   <= addr_in;
        stage_1.thread <= thread;
        stage_1.slot   <= addr_in[`SLOT_ADDR_WIDTH-1:0];
        if (rst) begin
            stage_1.cls <= addressing_pkg::class_shared;
        end else begin
            stage_1.cls <= cls;
        end
    end

    // slot selects the entry the memories read during this stage
    assign rd_slot = stage_1.slot;

    // ----------------------------------------
    // stage 2: offsets arrive, io_ready belongs to this instruction

    always_ff @(posedge clock) begin
        stage_2.addr   <= stage_1.addr;
        stage_2.slot   <= stage_1.slot;
        // counter copy lines up with the thread that was read
        stage_2.thread <= thread_d;
        if (rst) begin
            stage_2.cls <= addressing_pkg::class_shared;
            io_ready_q  <= 1'b0;
        end else begin
            stage_2.cls <= stage_1.cls;
            io_ready_q  <= io_ready;
        end
    end

    assign bump       = (stage_2.cls == addressing_pkg::class_indirect) && io_ready_q;
    assign bump_index = {stage_2.thread, stage_2.slot};

    always_ff @(posedge clock) begin
        if (rst) begin
            addr_out <= '0;
        end else begin
            case (stage_2.cls)
                addressing_pkg::class_private:  addr_out <= stage_2.addr + default_offset;
                addressing_pkg::class_indirect: addr_out <= pointer;
                default:                        addr_out <= stage_2.addr;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/indirect_offset_mem.sv ====
// per-thread, per-slot pointer and increment RAMs with pointer post-increment
`timescale 1ns/1ps
`default_nettype none

`include "addressing_macros.svh"

module indirect_offset_mem (
    input  logic                            clock,
    input  logic                            rst,
    input  addressing_pkg::offset_write_t   po_wr,
    input  addressing_pkg::offset_write_t   inc_wr,
    input  logic [`OFFSET_INDEX_WIDTH-1:0]  rd_index,
    input  logic                            bump,
    input  logic [`OFFSET_INDEX_WIDTH-1:0]  bump_index,
    output logic [`ADDR_WIDTH-1:0]          pointer
);

    logic [`ADDR_WIDTH-1:0] pointer_ram   [`OFFSET_ENTRIES];
    logic [`ADDR_WIDTH-1:0] increment_ram [`OFFSET_ENTRIES];

    logic [`ADDR_WIDTH-1:0] increment;
    logic [`ADDR_WIDTH-1:0] bumped_pointer;
    logic                   bump_wr;

    // ----------------------------------------
    // both RAMs read at the same entry

    always_ff @(posedge clock) begin
        pointer   <= pointer_ram[rd_index];
        increment <= increment_ram[rd_index];
    end

    // ----------------------------------------
    // post-increment writeback

    // wraps at 1024 through the adder width
    assign bumped_pointer = pointer + increment;

    // an ALU write to the same entry takes priority
    assign bump_wr = bump && !rst && !(po_wr.en && (po_wr.index == bump_index));

    always_ff @(posedge clock) begin
        if (bump_wr) begin
            pointer_ram[bump_index] <= bumped_pointer;
        end
        if (po_wr.en) begin
            pointer_ram[po_wr.index] <= po_wr.data;
        end
    end

    // increments change only through the ALU
    always_ff @(posedge clock) begin
        if (inc_wr.en) begin
            increment_ram[inc_wr.index] <= inc_wr.data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/default_offset_mem.sv ====
// per-thread default offset RAM, written by the ALU and read one thread per cycle
`timescale 1ns/1ps
`default_nettype none

`include "addressing_macros.svh"

module default_offset_mem (
    input  logic                            clock,
    input  addressing_pkg::offset_write_t   wr,
    input  logic [`THREAD_ADDR_WIDTH-1:0]   rd_thread,
    output logic [`ADDR_WIDTH-1:0]          offset
);

    logic [`ADDR_WIDTH-1:0] offset_ram [`THREAD_COUNT];
    logic [`THREAD_ADDR_WIDTH-1:0] wr_thread;

    // the decoder only hits the first THREAD_COUNT entries
    assign wr_thread = wr.index[`THREAD_ADDR_WIDTH-1:0];

    // ----------------------------------------
    // write port
    always_ff @(posedge clock) begin
        if (wr.en) begin
            offset_ram[wr_thread] <= wr.data;
        end
    end

    // ----------------------------------------
    // registered read, old data on a same-cycle write
    always_ff @(posedge clock) begin
        offset <= offset_ram[rd_thread];
    end

endmodule

`default_nettype wire

// ==== logic/thread_number.sv ====
// round-robin thread counter with a one-cycle delayed copy for the second stage
`timescale 1ns/1ps
`default_nettype none

`include "addressing_macros.svh"

module thread_number (
    input  logic                            clock,
    input  logic                            rst,
    output logic [`THREAD_ADDR_WIDTH-1:0]   thread,
    output logic [`THREAD_ADDR_WIDTH-1:0]   thread_d
);

    localparam int unsigned LAST_THREAD = `THREAD_COUNT - 1;

    // one thread per clock, wrapping after the last one
    always_ff @(posedge clock) begin
        if (rst) begin
            thread <= '0;
        end else if (thread == LAST_THREAD[`THREAD_ADDR_WIDTH-1:0]) begin
            thread <= '0;
        end else begin
            thread <= thread + 1'b1;
        end
    end

    // thread that was current when the first stage sampled its address
    always_ff @(posedge clock) begin
        if (rst) begin
            thread_d <= '0;
        end else begin
            thread_d <= thread;
        end
    end

endmodule

`default_nettype wire

// ==== logic/addressing_pkg.sv ====
// address translation types: address classes and the structs passed between blocks
`default_nettype none

`include "addressing_macros.svh"

package addressing_pkg;

    // ----------------------------------------
    // class of a read address
    typedef enum logic [1:0] {
        class_shared   = 2'd0,
        class_private  = 2'd1,
        class_indirect = 2'd2
    } addr_class_e;

    // ----------------------------------------
    // one decoded ALU write into an offset memory
    // index is the thread for default offsets, thread*4+slot otherwise
    typedef struct packed {
        logic                               en;
        logic [`OFFSET_INDEX_WIDTH-1:0]     index;
        logic [`ADDR_WIDTH-1:0]             data;
    } offset_write_t;

    // state carried from the classify stage to the select stage
    typedef struct packed {
        addr_class_e                        cls;
        logic [`ADDR_WIDTH-1:0]             addr;
        logic [`THREAD_ADDR_WIDTH-1:0]      thread;
        logic [`SLOT_ADDR_WIDTH-1:0]        slot;
    } translate_stage_t;

endpackage

`default_nettype wire

// ==== logic/addressing_macros.svh ====
// address translation macros: widths, thread count, window bounds and write map
`ifndef ADDRESSING_MACROS_SVH
`define ADDRESSING_MACROS_SVH

// ----------------------------------------
// datapath widths
`define ADDR_WIDTH          10
`define WORD_WIDTH          36
`define D_OPERAND_WIDTH     10

// threads and indirect slots
`define THREAD_COUNT        8
`define THREAD_ADDR_WIDTH   3
`define INDIRECT_SLOTS      4
`define SLOT_ADDR_WIDTH     2

// one entry per thread and slot
`define OFFSET_ENTRIES      (`THREAD_COUNT * `INDIRECT_SLOTS)
`define OFFSET_INDEX_WIDTH  5

// ----------------------------------------
// read address windows
`define SHARED_LIMIT        10'h100
`define INDIRECT_BASE       10'h3FC

// ALU write map
`define DO_WRITE_BASE       10'h200
`define DO_WRITE_COUNT      10'd8
`define PO_WRITE_BASE       10'h210
`define PO_WRITE_COUNT      10'd32
`define INC_WRITE_BASE      10'h230
`define INC_WRITE_COUNT     10'd32

// low bit of each data field within the ALU word
`define DO_WORD_OFFSET      0
`define PO_WORD_OFFSET      0
`define INC_WORD_OFFSET     12

`endif
